/* logic/irq_ack_tracker.sv */
// Core acknowledge tracker

module irq_ack_tracker
  import irq_line_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       ack_i,
  input  logic [5:0] ack_id_i,
  output logic       id_we_o,
  output logic [7:0] ack_cnt_o,
  output logic       log_req_o,
  output log_entry_t log_entry_o,
  input  logic       log_gnt_i
);

  logic       id_we_q;
  logic [7:0] ack_cnt_q;
  logic       log_req_q;
  logic [5:0] ack_id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_we_q   <= 1'b0;
      ack_cnt_q <= '0;
      log_req_q <= 1'b0;
    end else begin
      // One store strobe per ack
      id_we_q <= ack_i;
      if (ack_i) begin
        ack_cnt_q <= ack_cnt_q + 8'd1;
        log_req_q <= 1'b1;
      end else if (log_gnt_i) begin
        log_req_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ack_i) begin
      ack_id_q <= ack_id_i;
    end
  end

  assign id_we_o          = id_we_q;
  assign ack_cnt_o        = ack_cnt_q;
  assign log_req_o        = log_req_q;
  assign log_entry_o.kind = EVT_ACK;
  assign log_entry_o.id   = ack_id_q;

  // Top priority at the arbiter keeps a single entry in flight
  a_no_ack_while_pending : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |-> !(log_req_q && !log_gnt_i));

endmodule

/* logic/irq_cfg_pkg.sv */
// Interrupt configuration types

package irq_cfg_pkg;

  // Source of the interrupt lines
  typedef enum logic [1:0] {
    STANDARD         = 2'd0,
    RANDOM           = 2'd1,
    PC_TRIG          = 2'd2,
    SOFTWARE_DEFINED = 2'd3
  } irq_mode_e;

  // Random source FSM states
  typedef enum logic [2:0] {
    IDLE,
    DRAW_ID,
    DRAW_WAIT,
    COUNT,
    RAISED,
    HOLD
  } rand_state_e;

  // Static settings, driven as plain levels
  typedef struct packed {
    logic [5:0]  min_id;
    logic [5:0]  max_id;
    logic [7:0]  min_cycles;
    logic [7:0]  max_cycles;
    logic [31:0] pc_trig;
  } irq_cfg_t;

endpackage

/* logic/irq_event_log.sv */
// Circular interrupt event log

`include "irq_gen_macros.svh"

module irq_event_log
  import irq_line_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              we_i,
  input  log_entry_t        wdata_i,
  input  logic [`LOG_AW-1:0] raddr_i,
  output log_entry_t        rdata_o,
  output logic [`LOG_AW:0]  count_o
);

  log_entry_t         mem_q [`LOG_DEPTH];
  log_entry_t         rdata_q;
  logic [`LOG_AW-1:0] wptr_q;
  logic [`LOG_AW:0]   count_q;

  // Pointer wraps by width, count stops at full
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      count_q <= '0;
    end else if (we_i) begin
      wptr_q <= wptr_q + 1'b1;
      if (count_q != (`LOG_AW+1)'(`LOG_DEPTH)) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Storage and registered read port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[wptr_q] <= wdata_i;
    end
    rdata_q <= mem_q[raddr_i];
  end

  assign rdata_o = rdata_q;
  assign count_o = count_q;

endmodule

/* logic/irq_gen_macros.svh */
// Interrupt generator macros

`ifndef IRQ_GEN_MACROS_SVH
`define IRQ_GEN_MACROS_SVH

////////////////////////////////////////
// Line counts
////////////////////////////////////////

// Fast interrupt lines of the core
`define IRQ_FAST_W 48
// Software, timer, external and fast lines together
`define IRQ_LINES_W 51

////////////////////////////////////////
// Event log and LFSR
////////////////////////////////////////

`define LOG_DEPTH 16
`define LOG_AW 4
// Must never be zero or the LFSR locks up
`define LFSR_SEED 32'h5EED_C0DE

`endif

/* logic/irq_gen_top.sv */
// Interrupt generator top

`include "irq_gen_macros.svh"

module irq_gen_top
  import irq_cfg_pkg::*;
  import irq_line_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  irq_mode_e          mode_i,
  input  irq_cfg_t           cfg_i,
  input  logic [63:0]        irq_lines_i,
  input  logic [31:0]        pc_i,
  input  logic               irq_ack_i,
  input  logic [5:0]         irq_ack_id_i,
  output irq_lines_t         irq_lines_o,
  output logic [5:0]         irq_act_id_o,
  output logic               irq_act_valid_o,
  output logic               irq_ack_o,
  output logic               irq_id_we_o,
  output logic [7:0]         irq_ack_cnt_o,
  input  logic [`LOG_AW-1:0] log_raddr_i,
  output log_entry_t         log_rdata_o,
  output logic [`LOG_AW:0]   log_count_o
);

  irq_mode_e        mode_q;
  irq_lines_t       rnd_lines;
  irq_lines_t       pc_lines;
  logic [5:0]       rnd_id;
  logic             rnd_valid;
  logic             pc_hit;
  logic       [1:0] log_req;
  logic       [1:0] log_gnt;
  log_entry_t [1:0] log_entry;
  logic             log_we;
  log_entry_t       log_wdata;

  ////////////////////////////////////////
  // Line sources and selector
  ////////////////////////////////////////

  irq_line_sel u_line_sel (
    .clk_i, .rst_ni, .mode_i, .sw_word_i(irq_lines_i), .rnd_lines_i(rnd_lines),
    .pc_lines_i(pc_lines), .mode_q_o(mode_q), .lines_o(irq_lines_o)
  );

  irq_rand_src u_rand_src (
    .clk_i, .rst_ni, .mode_q_i(mode_q), .cfg_i, .lines_o(rnd_lines), .act_id_o(rnd_id),
    .act_valid_o(rnd_valid), .log_req_o(log_req[1]), .log_entry_o(log_entry[1]),
    .log_gnt_i(log_gnt[1])
  );

  irq_pc_src u_pc_src (
    .clk_i, .rst_ni, .mode_q_i(mode_q), .pc_i, .pc_trig_i(cfg_i.pc_trig),
    .sw_word_i(irq_lines_i), .lines_o(pc_lines), .hit_o(pc_hit)
  );

  // PC hit reports id 0
  assign irq_act_valid_o = rnd_valid | pc_hit;
  assign irq_act_id_o    = pc_hit ? 6'd0 : rnd_id;
  assign irq_ack_o       = irq_ack_i;

  ////////////////////////////////////////
  // Acknowledges and event log
  ////////////////////////////////////////

  irq_ack_tracker u_ack_tracker (
    .clk_i, .rst_ni, .ack_i(irq_ack_i), .ack_id_i(irq_ack_id_i), .id_we_o(irq_id_we_o),
    .ack_cnt_o(irq_ack_cnt_o), .log_req_o(log_req[0]), .log_entry_o(log_entry[0]),
    .log_gnt_i(log_gnt[0])
  );

  irq_log_arbiter u_log_arbiter (
    .req_i(log_req), .entry_i(log_entry), .gnt_o(log_gnt), .we_o(log_we), .wdata_o(log_wdata)
  );

  irq_event_log u_event_log (
    .clk_i, .rst_ni, .we_i(log_we), .wdata_i(log_wdata), .raddr_i(log_raddr_i),
    .rdata_o(log_rdata_o), .count_o(log_count_o)
  );

endmodule

/* logic/irq_line_pkg.sv */
// Interrupt line and log types

`include "irq_gen_macros.svh"

package irq_line_pkg;

  // Core interrupt lines, software line is the MSB
  // Random id rule
  //   id 0 software, id 1 timer, id 2 external
  //   id 3 to 50 map to fast lines 0 to 47
  typedef struct packed {
    logic                   software;
    logic                   timer;
    logic                   external;
    logic [`IRQ_FAST_W-1:0] fast;
  } irq_lines_t;

  // Kind of a log entry
  typedef enum logic {
    EVT_ISSUE = 1'b0,
    EVT_ACK   = 1'b1
  } evt_kind_e;

  typedef struct packed {
    evt_kind_e  kind;
    logic [5:0] id;
  } log_entry_t;

  // Software word to line mapping
  function automatic irq_lines_t map_sw_word(input logic [63:0] word);
    irq_lines_t lines;
    lines.software = word[3];
    lines.timer    = word[7];
    lines.external = word[11];
    // Upper 48 bits feed the fast lines
    lines.fast     = word[63:16];
    return lines;
  endfunction

endpackage

/* logic/irq_line_sel.sv */
// Interrupt line selector

module irq_line_sel
  import irq_cfg_pkg::*;
  import irq_line_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  irq_mode_e   mode_i,
  input  logic [63:0] sw_word_i,
  input  irq_lines_t  rnd_lines_i,
  input  irq_lines_t  pc_lines_i,
  output irq_mode_e   mode_q_o,
  output irq_lines_t  lines_o
);

  irq_mode_e  mode_q;
  irq_lines_t lines_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q  <= STANDARD;
      lines_q <= '0;
    end else begin
      mode_q <= mode_i;
      unique case (mode_q)
        RANDOM:  lines_q <= rnd_lines_i;
        PC_TRIG: lines_q <= pc_lines_i;
        // Zero word keeps the last mapping
        SOFTWARE_DEFINED: begin
          if (|sw_word_i) begin
            lines_q <= map_sw_word(sw_word_i);
          end
        end
        default: lines_q <= '0;
      endcase
    end
  end

  assign mode_q_o = mode_q;
  assign lines_o  = lines_q;

endmodule

/* logic/irq_log_arbiter.sv */
// Event log write arbiter

module irq_log_arbiter
  import irq_line_pkg::*;
(
  input  logic             [1:0] req_i,
  input  log_entry_t       [1:0] entry_i,
  output logic             [1:0] gnt_o,
  output logic                   we_o,
  output log_entry_t             wdata_o
);

  ////////////////////////////////////////
  // Fixed priority grant
  ////////////////////////////////////////

  // Requester 0 is the ack tracker and always wins
  // Requester 1 is the random source
  always_comb begin
    gnt_o = 2'b00;
    if (req_i[0]) begin
      gnt_o[0] = 1'b1;
    end else if (req_i[1]) begin
      gnt_o[1] = 1'b1;
    end
  end

  // Log write happens in the grant cycle
  assign we_o = |gnt_o;

  always_comb begin
    wdata_o = entry_i[1];
    if (gnt_o[0]) begin
      wdata_o = entry_i[0];
    end
  end

  // Single grant, only to a requester
  always_comb begin
    a_gnt_legal : assert ($onehot0(gnt_o) && ((gnt_o & ~req_i) == 2'b00))
      else $error("Illegal log grant %b for request %b", gnt_o, req_i);
  end

endmodule

/* logic/irq_pc_src.sv */
// Program counter triggered source

module irq_pc_src
  import irq_cfg_pkg::*;
  import irq_line_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  irq_mode_e   mode_q_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] pc_trig_i,
  input  logic [63:0] sw_word_i,
  output irq_lines_t  lines_o,
  output logic        hit_o
);

  typedef enum logic [1:0] {
    PC_ARMED,
    PC_RAISED,
    PC_WAIT,
    PC_DONE
  } pc_state_e;

  localparam irq_lines_t SW_ONLY = '{software: 1'b1, default: '0};

  pc_state_e   state_q;
  irq_lines_t  lines_q;
  logic        hit_q;
  logic [63:0] ref_word_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PC_ARMED;
      lines_q <= '0;
      hit_q   <= 1'b0;
    end else begin
      hit_q <= 1'b0;
      if (mode_q_i != PC_TRIG) begin
        state_q <= PC_ARMED;
        lines_q <= '0;
      end else begin
        unique case (state_q)
          // Software line on a PC match
          PC_ARMED: begin
            if (pc_i == pc_trig_i) begin
              lines_q <= SW_ONLY;
              state_q <= PC_RAISED;
            end
          end
          // Hit pulse lines up with the selector output
          PC_RAISED: begin
            hit_q   <= 1'b1;
            state_q <= PC_WAIT;
          end
          // Follow the first change of the software word
          PC_WAIT: begin
            if (sw_word_i != ref_word_q) begin
              lines_q <= map_sw_word(sw_word_i);
              state_q <= PC_DONE;
            end
          end
          default: state_q <= PC_DONE;
        endcase
      end
    end
  end

  // Reference word taken at the match
  always_ff @(posedge clk_i) begin
    if (state_q == PC_ARMED) begin
      ref_word_q <= sw_word_i;
    end
  end

  assign lines_o = lines_q;
  assign hit_o   = hit_q;

endmodule

/* logic/irq_rand_src.sv */
// Random interrupt source

`include "irq_gen_macros.svh"

module irq_rand_src
  import irq_cfg_pkg::*;
  import irq_line_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  irq_mode_e  mode_q_i,
  input  irq_cfg_t   cfg_i,
  output irq_lines_t lines_o,
  output logic [5:0] act_id_o,
  output logic       act_valid_o,
  output logic       log_req_o,
  output log_entry_t log_entry_o,
  input  logic       log_gnt_i
);

  rand_state_e state_q;
  logic [31:0] lfsr_q;
  logic [31:0] lfsr_next;
  logic [5:0]  id_q;
  logic [7:0]  wait_q;
  irq_lines_t  lines_q;
  irq_lines_t  id_lines;
  logic        act_valid_q;
  logic        log_req_q;
  logic [5:0]  draw_id;
  logic [7:0]  draw_wait;
  logic        id_ok;
  logic        wait_ok;

  ////////////////////////////////////////
  // LFSR and draws
  ////////////////////////////////////////

  // Galois form, shifts right every cycle
  assign lfsr_next = (lfsr_q >> 1) ^ ({32{lfsr_q[0]}} & 32'h8020_0003);

  assign draw_id   = lfsr_q[5:0];
  assign draw_wait = lfsr_q[15:8];

  // Reject ids outside the range or above the last line
  assign id_ok = (draw_id >= cfg_i.min_id) && (draw_id <= cfg_i.max_id) &&
                 (draw_id <= 6'(`IRQ_LINES_W - 1));
  assign wait_ok = (draw_wait >= cfg_i.min_cycles) && (draw_wait <= cfg_i.max_cycles);

  // One-hot line for the latched id
  always_comb begin
    id_lines = '0;
    if (id_q == 6'd0) begin
      id_lines.software = 1'b1;
    end else if (id_q == 6'd1) begin
      id_lines.timer = 1'b1;
    end else if (id_q == 6'd2) begin
      id_lines.external = 1'b1;
    end else if (id_q <= 6'(`IRQ_LINES_W - 1)) begin
      id_lines.fast[id_q - 6'd3] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      lfsr_q      <= `LFSR_SEED;
      id_q        <= '0;
      wait_q      <= '0;
      lines_q     <= '0;
      act_valid_q <= 1'b0;
      log_req_q   <= 1'b0;
    end else begin
      lfsr_q      <= lfsr_next;
      act_valid_q <= 1'b0;
      // Request drops the cycle after its grant
      if (log_gnt_i) begin
        log_req_q <= 1'b0;
      end
      if (mode_q_i != RANDOM) begin
        state_q <= IDLE;
        lines_q <= '0;
      end else begin
        unique case (state_q)
          IDLE: state_q <= DRAW_ID;
          // One retry per LFSR step
          DRAW_ID: begin
            if (id_ok) begin
              id_q    <= draw_id;
              state_q <= DRAW_WAIT;
            end
          end
          DRAW_WAIT: begin
            if (wait_ok) begin
              wait_q  <= draw_wait;
              state_q <= COUNT;
            end
          end
          COUNT: begin
            if (wait_q == 8'd0) begin
              lines_q <= id_lines;
              state_q <= RAISED;
            end else begin
              wait_q <= wait_q - 8'd1;
            end
          end
          // Valid and log request line up with the selector output
          RAISED: begin
            act_valid_q <= 1'b1;
            log_req_q   <= 1'b1;
            state_q     <= HOLD;
          end
          // Line stays up until the mode changes
          HOLD: state_q <= HOLD;
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  assign lines_o           = lines_q;
  assign act_id_o          = id_q;
  assign act_valid_o       = act_valid_q;
  assign log_req_o         = log_req_q;
  assign log_entry_o.kind  = EVT_ISSUE;
  assign log_entry_o.id    = id_q;

  // At most one line raised at a time
  a_lines_onehot0 : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(lines_o));

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the interrupt generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module irq_gen_tb -f tb.f -o irq_gen_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/irq_gen_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

/* tb.f */
+incdir+logic
logic/irq_cfg_pkg.sv
logic/irq_line_pkg.sv
logic/irq_rand_src.sv
logic/irq_pc_src.sv
logic/irq_line_sel.sv
logic/irq_ack_tracker.sv
logic/irq_log_arbiter.sv
logic/irq_event_log.sv
logic/irq_gen_top.sv
test/irq_gen_tb.sv

/* test/irq_gen_tb.sv */
// Interrupt generator testbench

`include "irq_gen_macros.svh"

module irq_gen_tb
  import irq_cfg_pkg::*;
  import irq_line_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD    = 100;
  localparam int          RESET_CYCLES  = 10;
  localparam logic [31:0] RAND_SEED     = 32'h885faf4e;
  localparam logic [31:0] PC_MATCH_ADDR = 32'h0000_1A40;
  localparam int          SW_WORDS      = 25;
  // Budget per random draw with two draws per random run
  localparam int          DRAW_CYCLES   = 300;
  localparam int          RAND_RUNS     = 5;
  localparam int          FIXED_CYCLES  = 600;
  localparam int          WATCHDOG_CYCLES =
    FIXED_CYCLES + RAND_RUNS * (2 * DRAW_CYCLES + 256 + 20);

  logic               clk_i;
  logic               rst_ni;
  irq_mode_e          mode_i;
  irq_cfg_t           cfg_i;
  logic [63:0]        irq_lines_i;
  logic [31:0]        pc_i;
  logic               irq_ack_i;
  logic [5:0]         irq_ack_id_i;
  irq_lines_t         irq_lines_o;
  logic [5:0]         irq_act_id_o;
  logic               irq_act_valid_o;
  logic               irq_ack_o;
  logic               irq_id_we_o;
  logic [7:0]         irq_ack_cnt_o;
  logic [`LOG_AW-1:0] log_raddr_i;
  log_entry_t         log_rdata_o;
  logic [`LOG_AW:0]   log_count_o;

  int          errors;
  int          checks;
  int          cyc;
  int          acks_sent;
  int          start_err;

  // Pending line expectations for the compare process
  int          due_q[$];
  logic [50:0] exp_q[$];
  string       name_q[$];

  // Event log model filled by the priority rule
  log_entry_t  exp_log [`LOG_DEPTH];
  int          exp_wptr;
  int          exp_cnt;
  logic        ack_pend;
  logic        iss_pend;
  logic [5:0]  ack_id;
  logic [5:0]  iss_id;

  irq_gen_top dut0 (
    .clk_i, .rst_ni, .mode_i, .cfg_i, .irq_lines_i, .pc_i, .irq_ack_i, .irq_ack_id_i,
    .irq_lines_o, .irq_act_id_o, .irq_act_valid_o, .irq_ack_o, .irq_id_we_o,
    .irq_ack_cnt_o, .log_raddr_i, .log_rdata_o, .log_count_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  // Bit 3 software, 7 timer, 11 external, 63..16 fast
  function automatic logic [50:0] ref_map(input logic [63:0] w);
    ref_map = {w[3], w[7], w[11], w[63:16]};
  endfunction

  // Single line named by a random id
  function automatic logic [50:0] line_for_id(input logic [5:0] id);
    logic [50:0] l;
    l = '0;
    if (id == 6'd0) begin
      l[50] = 1'b1;
    end else if (id == 6'd1) begin
      l[49] = 1'b1;
    end else if (id == 6'd2) begin
      l[48] = 1'b1;
    end else if (id <= 6'd50) begin
      l[int'(id) - 3] = 1'b1;
    end
    return l;
  endfunction

  function automatic logic [63:0] rand_word();
    logic [63:0] w;
    w = {$urandom, $urandom};
    if (w == '0) begin
      w = 64'h1;
    end
    return w;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int first_err);
    $display("Test %-10s done, %0d errors", name, errors - first_err);
  endtask

  task automatic log_push(input log_entry_t e);
    exp_log[exp_wptr] = e;
    exp_wptr = (exp_wptr + 1) % `LOG_DEPTH;
    if (exp_cnt < `LOG_DEPTH) begin
      exp_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // Compare process and log model
  ////////////////////////////////////////

  // Lines are checked at the falling edge they are due
  always @(negedge clk_i) begin
    if (due_q.size() > 0 && due_q[0] <= cyc) begin
      check_eq(name_q.pop_front(), 64'(exp_q.pop_front()), 64'(irq_lines_o));
      void'(due_q.pop_front());
    end
  end

  // Uses the pre-edge values that the DUT samples
  always @(posedge clk_i) begin
    log_entry_t e;
    if (rst_ni) begin
      if (irq_act_valid_o && mode_i == RANDOM) begin
        iss_pend = 1'b1;
        iss_id   = irq_act_id_o;
      end
      // Ack entry beats a waiting issue entry
      if (ack_pend) begin
        e.kind = EVT_ACK;
        e.id   = ack_id;
        log_push(e);
        ack_pend = 1'b0;
      end else if (iss_pend) begin
        e.kind = EVT_ISSUE;
        e.id   = iss_id;
        log_push(e);
        iss_pend = 1'b0;
      end
      if (irq_ack_i) begin
        ack_pend = 1'b1;
        ack_id   = irq_ack_id_i;
      end
    end
  end

  ////////////////////////////////////////
  // Test tasks
  ////////////////////////////////////////

  task automatic run_sw_defined();
    logic [63:0] word;
    logic [50:0] held;
    held = '0;
    @(posedge clk_i);
    mode_i <= SOFTWARE_DEFINED;
    for (int i = 0; i < SW_WORDS; i++) begin
      // Every fifth word is zero and holds the output
      if (i % 5 == 4) begin
        word = '0;
      end else begin
        word = rand_word();
        held = ref_map(word);
      end
      @(posedge clk_i);
      irq_lines_i <= word;
      due_q.push_back(cyc + 2);
      exp_q.push_back(held);
      name_q.push_back($sformatf("sw_map_%0d", i));
    end
    while (due_q.size() > 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic run_random(input logic [5:0] lo_id, input logic [5:0] hi_id,
                            input logic [7:0] lo_cyc, input logic [7:0] hi_cyc,
                            input bit with_acks);
    int         limit;
    int         waited;
    bit         seen;
    logic [5:0] id;
    limit  = 2 * DRAW_CYCLES + int'(hi_cyc) + 10;
    waited = 0;
    seen   = 1'b0;
    @(posedge clk_i);
    cfg_i.min_id     <= lo_id;
    cfg_i.max_id     <= hi_id;
    cfg_i.min_cycles <= lo_cyc;
    cfg_i.max_cycles <= hi_cyc;
    mode_i           <= RANDOM;
    while (!seen && waited < limit) begin
      @(posedge clk_i);
      // Ack every cycle so one lands with the issue
      if (with_acks) begin
        irq_ack_i    <= 1'b1;
        irq_ack_id_i <= 6'($urandom);
        acks_sent++;
      end
      @(negedge clk_i);
      seen = irq_act_valid_o;
      waited++;
    end
    if (!seen) begin
      errors++;
      $display("No random interrupt within %0d cycles for ids %0d to %0d", limit, lo_id, hi_id);
    end else begin
      id = irq_act_id_o;
      check_eq("rnd_onehot", 64'd1, 64'($countones(irq_lines_o)));
      check_eq("rnd_id_range", 64'd1, 64'(id >= lo_id && id <= hi_id && id <= 6'd50));
      check_eq("rnd_line", 64'(line_for_id(id)), 64'(irq_lines_o));
    end
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
    mode_i    <= STANDARD;
    repeat (2) @(posedge clk_i);
  endtask

  task automatic ack_pulse(input logic [5:0] id);
    @(posedge clk_i);
    irq_ack_i    <= 1'b1;
    irq_ack_id_i <= id;
    acks_sent++;
    @(negedge clk_i);
    check_eq("ack_pass", 64'd1, 64'(irq_ack_o));
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
    @(negedge clk_i);
    check_eq("id_we_high", 64'd1, 64'(irq_id_we_o));
    @(posedge clk_i);
    @(negedge clk_i);
    check_eq("id_we_low", 64'd0, 64'(irq_id_we_o));
  endtask

  // Registered read with data one edge after the address
  task automatic read_log(input logic [`LOG_AW-1:0] addr, output log_entry_t got);
    @(posedge clk_i);
    log_raddr_i <= addr;
    @(posedge clk_i);
    @(negedge clk_i);
    got = log_rdata_o;
  endtask

  task automatic check_log(input string tag);
    int                 waited;
    log_entry_t         got;
    logic [`LOG_AW-1:0] addr;
    waited = 0;
    @(negedge clk_i);
    while ((ack_pend || iss_pend) && waited < 20) begin
      @(negedge clk_i);
      waited++;
    end
    if (ack_pend || iss_pend) begin
      errors++;
      $display("Log writes still pending at the end of %s", tag);
    end
    check_eq({tag, "_count"}, 64'(exp_cnt), 64'(log_count_o));
    for (int a = 0; a < exp_cnt; a++) begin
      addr = a[`LOG_AW-1:0];
      read_log(addr, got);
      check_eq($sformatf("%s_entry_%0d", tag, a), 64'(exp_log[a]), 64'(got));
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [63:0] w0;
    logic [63:0] w1;
    void'($urandom(RAND_SEED));
    errors       = 0;
    checks       = 0;
    cyc          = 0;
    acks_sent    = 0;
    exp_wptr     = 0;
    exp_cnt      = 0;
    ack_pend     = 1'b0;
    iss_pend     = 1'b0;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    mode_i       = STANDARD;
    cfg_i        = '0;
    cfg_i.pc_trig = PC_MATCH_ADDR;
    irq_lines_i  = '0;
    pc_i         = '0;
    irq_ack_i    = 1'b0;
    irq_ack_id_i = '0;
    log_raddr_i  = '0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    start_err = errors;
    @(negedge clk_i);
    check_eq("rst_lines", 64'd0, 64'(irq_lines_o));
    check_eq("rst_id_we", 64'd0, 64'(irq_id_we_o));
    check_eq("rst_act_valid", 64'd0, 64'(irq_act_valid_o));
    check_eq("rst_log_count", 64'd0, 64'(log_count_o));
    report_test("reset", start_err);

    start_err = errors;
    run_sw_defined();
    report_test("sw_defined", start_err);

    // Mode takes one edge and the lines one more
    start_err = errors;
    @(posedge clk_i);
    mode_i <= STANDARD;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_eq("std_clear", 64'd0, 64'(irq_lines_o));
    report_test("standard", start_err);

    start_err = errors;
    run_random(6'd0, 6'd2, 8'd0, 8'd15, 1'b0);
    run_random(6'd3, 6'd50, 8'd5, 8'd40, 1'b0);
    run_random(6'd10, 6'd20, 8'd20, 8'd60, 1'b0);
    run_random(6'd40, 6'd63, 8'd0, 8'd30, 1'b0);
    check_log("rnd_log");
    report_test("random", start_err);

    start_err = errors;
    w0 = rand_word();
    w1 = ~w0;
    @(posedge clk_i);
    irq_lines_i <= w0;
    pc_i        <= 32'h0000_0100;
    mode_i      <= PC_TRIG;
    for (int i = 0; i < 6; i++) begin
      @(posedge clk_i);
      pc_i <= pc_i + 32'd4;
      @(negedge clk_i);
      check_eq("pc_no_match", 64'd0, 64'(irq_lines_o));
    end
    @(posedge clk_i);
    pc_i <= PC_MATCH_ADDR;
    @(posedge clk_i);
    pc_i <= PC_MATCH_ADDR + 32'd4;
    @(posedge clk_i);
    @(negedge clk_i);
    check_eq("pc_sw_line", 64'(line_for_id(6'd0)), 64'(irq_lines_o));
    check_eq("pc_act_valid", 64'd1, 64'(irq_act_valid_o));
    check_eq("pc_act_id", 64'd0, 64'(irq_act_id_o));
    @(posedge clk_i);
    irq_lines_i <= w1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_eq("pc_follow_word", 64'(ref_map(w1)), 64'(irq_lines_o));
    @(posedge clk_i);
    mode_i <= STANDARD;
    repeat (2) @(posedge clk_i);
    report_test("pc_trigger", start_err);

    start_err = errors;
    for (int i = 0; i < 4; i++) begin
      ack_pulse(6'($urandom));
    end
    check_eq("ack_count", 64'(acks_sent[7:0]), 64'(irq_ack_cnt_o));
    // Acks overlap the random issue here
    run_random(6'd0, 6'd50, 8'd0, 8'd20, 1'b1);
    @(negedge clk_i);
    check_eq("ack_count_burst", 64'(acks_sent[7:0]), 64'(irq_ack_cnt_o));
    check_log("ack_log");
    report_test("ack_log", start_err);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Run limit from the summed test lengths
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule
